/* src/mbx_cfg_pkg.sv */
// Mailbox configuration constants
// Data path width and FIFO sizing shared by the RTL and the testbench

package mbx_cfg_pkg;

   // Word width on both the APB and the peripheral streams
   localparam int MBX_DW = 32;

   // FIFO address bits
   // Depth is 1 << MBX_AW, so 8 words per direction
   localparam int MBX_AW = 3;

endpackage

/* src/mbx_reg_pkg.sv */
// Mailbox APB register map
// Offsets, address width and status bit positions

package mbx_reg_pkg;

   // APB address width, byte addressed
   localparam int PADDR_W = 4;

   // Write only, a write pushes one word into the TX FIFO
   localparam logic [PADDR_W-1:0] REG_TXDATA = 4'h0;

   // Read only, a read pops one word from the RX FIFO
   localparam logic [PADDR_W-1:0] REG_RXDATA = 4'h4;

   // Read only, live FIFO flags
   localparam logic [PADDR_W-1:0] REG_STATUS = 4'h8;

   // Status word bit positions, other bits read as 0
   localparam int STAT_TX_FULL  = 0;
   localparam int STAT_RX_EMPTY = 1;

endpackage

/* src/async_fifo.sv */
// Dual-clock FIFO between two unrelated clocks
// Gray pointers cross through two-flop synchronizers, full and empty are registered

module async_fifo #(
   parameter int DW = 32,   // Word width
   parameter int AW = 3     // Address bits, at least 2
) (
   input  logic          wclk,
   input  logic          wrst_n,
   input  logic          rclk,
   input  logic          rrst_n,
   input  logic [DW-1:0] din,
   input  logic          push,
   input  logic          pop,
   output logic [DW-1:0] dout,
   output logic          full,
   output logic          empty
);

   logic [AW:0]   wptr_b, wptr_g;            // Write pointers, extra wrap bit
   logic [AW:0]   rptr_b, rptr_g;            // Read pointers, extra wrap bit
   logic [AW:0]   wptr_b_nxt, wptr_g_nxt;
   logic [AW:0]   rptr_b_nxt, rptr_g_nxt;
   logic [AW:0]   rptr_g_s1, rptr_g_s2;      // Read pointer seen in wclk domain
   logic [AW:0]   wptr_g_s1, wptr_g_s2;      // Write pointer seen in rclk domain
   logic [DW-1:0] mem [0:(1<<AW)-1];

   // Pointer advance, own guard against overflow and underflow
   assign wptr_b_nxt = wptr_b + {{AW{1'b0}}, push & ~full};
   assign wptr_g_nxt = (wptr_b_nxt >> 1) ^ wptr_b_nxt;   // Binary to Gray
   assign rptr_b_nxt = rptr_b + {{AW{1'b0}}, pop & ~empty};
   assign rptr_g_nxt = (rptr_b_nxt >> 1) ^ rptr_b_nxt;   // Binary to Gray

   // Write domain: pointers, read pointer sync, full flag
   always_ff @(posedge wclk or negedge wrst_n) begin
      if (!wrst_n) begin
         wptr_b    <= '0;
         wptr_g    <= '0;
         rptr_g_s1 <= '0;
         rptr_g_s2 <= '0;
         full      <= 1'b0;
      end else begin
         wptr_b    <= wptr_b_nxt;
         wptr_g    <= wptr_g_nxt;
         rptr_g_s1 <= rptr_g;                 // First sync stage
         rptr_g_s2 <= rptr_g_s1;
         // Full when next write lands one lap ahead of the synced read side
         full      <= wptr_g_nxt == {~rptr_g_s2[AW:AW-1], rptr_g_s2[AW-2:0]};
      end
   end

   // Read domain: pointers, write pointer sync, empty flag
   always_ff @(posedge rclk or negedge rrst_n) begin
      if (!rrst_n) begin
         rptr_b    <= '0;
         rptr_g    <= '0;
         wptr_g_s1 <= '0;
         wptr_g_s2 <= '0;
         empty     <= 1'b1;                   // Nothing stored after reset
      end else begin
         rptr_b    <= rptr_b_nxt;
         rptr_g    <= rptr_g_nxt;
         wptr_g_s1 <= wptr_g;                 // First sync stage
         wptr_g_s2 <= wptr_g_s1;
         empty     <= rptr_g_nxt == wptr_g_s2; // Caught up with writer
      end
   end

   // Memory write port on wclk
   always_ff @(posedge wclk) begin
      if (push & ~full)
         mem[wptr_b[AW-1:0]] <= din;
   end

   // Registered read port, dout valid one rclk after an accepted pop
   always_ff @(posedge rclk) begin
      if (pop & ~empty)
         dout <= mem[rptr_b[AW-1:0]];
   end

endmodule

/* src/apb_mbx_regs.sv */
// APB slave for the mailbox register map
// Pushes TX words, pops RX words with one wait state, reports FIFO flags

module apb_mbx_regs (
   input  logic                               rclk,
   input  logic                               rrst_n,
   input  logic                               psel,
   input  logic                               penable,
   input  logic                               pwrite,
   input  logic [mbx_reg_pkg::PADDR_W-1:0]    paddr,
   input  logic [mbx_cfg_pkg::MBX_DW-1:0]     pwdata,
   output logic [mbx_cfg_pkg::MBX_DW-1:0]     prdata,
   output logic                               pready,
   output logic                               pslverr,
   output logic                               tx_push,
   output logic [mbx_cfg_pkg::MBX_DW-1:0]     tx_wdata,
   input  logic                               tx_full,
   output logic                               rx_pop,
   input  logic [mbx_cfg_pkg::MBX_DW-1:0]     rx_rdata,
   input  logic                               rx_empty
);

   import mbx_cfg_pkg::*;
   import mbx_reg_pkg::*;

   logic              setup;       // Setup phase of a new transfer
   logic              hit_tx;
   logic              hit_rx;
   logic              hit_stat;
   logic              tx_ok;       // TXDATA write with room in the FIFO
   logic              rx_ok;       // RXDATA read with a word waiting
   logic              err;         // Any of the four error cases
   logic              rd_sel;      // Route FIFO output to prdata
   logic [MBX_DW-1:0] stat_word;
   logic [MBX_DW-1:0] prdata_q;    // Status or zero, captured at setup

   assign setup    = psel & ~penable;
   assign hit_tx   = paddr == REG_TXDATA;
   assign hit_rx   = paddr == REG_RXDATA;
   assign hit_stat = paddr == REG_STATUS;

   assign tx_ok = hit_tx & pwrite & ~tx_full;
   assign rx_ok = hit_rx & ~pwrite & ~rx_empty;

   // Error decode
   always_comb begin
      err = 1'b0;
      if (!(hit_tx | hit_rx | hit_stat))
         err = 1'b1;                        // Unmapped offset
      else if (pwrite & ~hit_tx)
         err = 1'b1;                        // Read-only target
      else if (hit_tx & pwrite & tx_full)
         err = 1'b1;                        // Word dropped
      else if (hit_rx & ~pwrite & rx_empty)
         err = 1'b1;                        // Nothing to pop
   end

   // Live flags, remaining bits zero
   always_comb begin
      stat_word                = '0;
      stat_word[STAT_TX_FULL]  = tx_full;
      stat_word[STAT_RX_EMPTY] = rx_empty;
   end

   // pwdata holds through the access cycle where the push strobe sits
   assign tx_wdata = pwdata;

   // Handshake and FIFO strobes
   always_ff @(posedge rclk or negedge rrst_n) begin
      if (!rrst_n) begin
         pready  <= 1'b0;
         pslverr <= 1'b0;
         tx_push <= 1'b0;
         rx_pop  <= 1'b0;
         rd_sel  <= 1'b0;
      end else begin
         // One-cycle strobes by default
         pready  <= 1'b0;
         pslverr <= 1'b0;
         tx_push <= 1'b0;
         rx_pop  <= 1'b0;
         rd_sel  <= 1'b0;
         if (setup) begin
            if (rx_ok) begin
               rx_pop  <= 1'b1;             // Pop in first access cycle
            end else begin
               pready  <= 1'b1;             // Zero wait states
               pslverr <= err;
               tx_push <= tx_ok;
            end
         end else if (rx_pop) begin
            pready <= 1'b1;                 // Registered FIFO data valid now
            rd_sel <= 1'b1;
         end
      end
   end

   // Read data for status and error responses
   always_ff @(posedge rclk) begin
      if (setup)
         prdata_q <= (hit_stat & ~pwrite) ? stat_word : '0;
   end

   assign prdata = rd_sel ? rx_rdata : prdata_q;

endmodule

/* src/stream_tx_port.sv */
// TX stream output stage on wclk
// Prefetches from the registered-read FIFO into a one-entry valid/ready register

module stream_tx_port (
   input  logic                            wclk,
   input  logic                            wrst_n,
   output logic                            fifo_pop,
   input  logic [mbx_cfg_pkg::MBX_DW-1:0]  fifo_data,
   input  logic                            fifo_empty,
   output logic [mbx_cfg_pkg::MBX_DW-1:0]  out_data,
   output logic                            out_valid,
   input  logic                            out_ready
);

   logic load_pend;    // Pop accepted, FIFO dout valid this cycle
   logic slot_free;    // Output register empty or draining now

   assign slot_free = ~out_valid | out_ready;

   // One word in flight at most
   assign fifo_pop = ~fifo_empty & ~load_pend & slot_free;

   // Control state
   always_ff @(posedge wclk or negedge wrst_n) begin
      if (!wrst_n) begin
         load_pend <= 1'b0;
         out_valid <= 1'b0;
      end else begin
         load_pend <= fifo_pop;
         if (load_pend)
            out_valid <= 1'b1;         // Word arrives from FIFO
         else if (out_ready)
            out_valid <= 1'b0;         // Transfer done, nothing behind it
      end
   end

   // Output word, held until the transfer
   always_ff @(posedge wclk) begin
      if (load_pend)
         out_data <= fifo_data;
   end

endmodule

/* src/cdc_mailbox.sv */
// Clock-domain-crossing mailbox top level
// APB on rclk, valid/ready streams on wclk, one async FIFO per direction

module cdc_mailbox (
   input  logic                               rclk,
   input  logic                               rrst_n,
   input  logic                               wclk,
   input  logic                               wrst_n,
   input  logic                               psel,
   input  logic                               penable,
   input  logic                               pwrite,
   input  logic [mbx_reg_pkg::PADDR_W-1:0]    paddr,
   input  logic [mbx_cfg_pkg::MBX_DW-1:0]     pwdata,
   output logic [mbx_cfg_pkg::MBX_DW-1:0]     prdata,
   output logic                               pready,
   output logic                               pslverr,
   output logic [mbx_cfg_pkg::MBX_DW-1:0]     out_data,
   output logic                               out_valid,
   input  logic                               out_ready,
   input  logic [mbx_cfg_pkg::MBX_DW-1:0]     in_data,
   input  logic                               in_valid,
   output logic                               in_ready
);

   import mbx_cfg_pkg::*;

   logic              tx_push;     // rclk side of TX FIFO
   logic [MBX_DW-1:0] tx_wdata;
   logic              tx_full;
   logic              tx_pop;      // wclk side of TX FIFO
   logic [MBX_DW-1:0] tx_dout;
   logic              tx_empty;
   logic              rx_pop;      // rclk side of RX FIFO
   logic [MBX_DW-1:0] rx_dout;
   logic              rx_empty;
   logic              rx_full;     // wclk side of RX FIFO

   apb_mbx_regs u_regs (
      .rclk     (rclk),     .rrst_n   (rrst_n),
      .psel     (psel),     .penable  (penable),
      .pwrite   (pwrite),   .paddr    (paddr),
      .pwdata   (pwdata),   .prdata   (prdata),
      .pready   (pready),   .pslverr  (pslverr),
      .tx_push  (tx_push),  .tx_wdata (tx_wdata),
      .tx_full  (tx_full),  .rx_pop   (rx_pop),
      .rx_rdata (rx_dout),  .rx_empty (rx_empty)
   );

   // CPU to peripheral, written on rclk
   async_fifo #(.DW(MBX_DW), .AW(MBX_AW)) u_tx_fifo (
      .wclk  (rclk),     .wrst_n (rrst_n),
      .rclk  (wclk),     .rrst_n (wrst_n),
      .din   (tx_wdata), .push   (tx_push),
      .pop   (tx_pop),   .dout   (tx_dout),
      .full  (tx_full),  .empty  (tx_empty)
   );

   // Peripheral to CPU, written on wclk
   async_fifo #(.DW(MBX_DW), .AW(MBX_AW)) u_rx_fifo (
      .wclk  (wclk),     .wrst_n (wrst_n),
      .rclk  (rclk),     .rrst_n (rrst_n),
      .din   (in_data),  .push   (in_valid),   // FIFO drops push while full
      .pop   (rx_pop),   .dout   (rx_dout),
      .full  (rx_full),  .empty  (rx_empty)
   );

   stream_tx_port u_txport (
      .wclk       (wclk),      .wrst_n    (wrst_n),
      .fifo_pop   (tx_pop),    .fifo_data (tx_dout),
      .fifo_empty (tx_empty),  .out_data  (out_data),
      .out_valid  (out_valid), .out_ready (out_ready)
   );

   assign in_ready = ~rx_full;   // Accept while RX has room

endmodule

/* dv/cdc_mailbox_checker.sv */
// Concurrent checks on one async FIFO
// Gray pointer steps, flag sanity and read port hold

module cdc_mailbox_checker #(
   parameter int DW = 32,
   parameter int AW = 3
) (
   input logic          wclk,
   input logic          wrst_n,
   input logic          rclk,
   input logic          rrst_n,
   input logic [AW:0]   wptr_g,
   input logic [AW:0]   rptr_g,
   input logic          pop,
   input logic          empty,
   input logic          full,
   input logic [DW-1:0] dout
);

   int unsigned fail_cnt = 0;   // Failure tally

   // Gray pointers move by one bit at most
   a_wptr_step: assert property (@(posedge wclk) disable iff (!wrst_n)
      $countones(wptr_g ^ $past(wptr_g)) <= 1)
      else begin
         fail_cnt++;
         $error("write Gray pointer changed more than one bit");
      end
   a_rptr_step: assert property (@(posedge rclk) disable iff (!rrst_n)
      $countones(rptr_g ^ $past(rptr_g)) <= 1)
      else begin
         fail_cnt++;
         $error("read Gray pointer changed more than one bit");
      end

   a_flags_excl: assert property (@(posedge rclk) disable iff (!rrst_n || !wrst_n)
      !(empty && full))
      else begin
         fail_cnt++;
         $error("empty and full high together");
      end

   // Reset values seen on the first edge out of reset
   a_rst_empty: assert property (@(posedge rclk) $rose(rrst_n) |-> empty)
      else begin
         fail_cnt++;
         $error("empty low after reset");
      end
   a_rst_full: assert property (@(posedge wclk) $rose(wrst_n) |-> !full)
      else begin
         fail_cnt++;
         $error("full high after reset");
      end

   a_dout_hold: assert property (@(posedge rclk) disable iff (!rrst_n)
      !$past(pop && !empty) |-> $stable(dout))
      else begin
         fail_cnt++;
         $error("dout changed without an accepted pop");
      end

endmodule

/* dv/cdc_mailbox_tb.sv */
// Testbench for the CDC mailbox
// Replays the stim file over APB and both streams, checks the TX stream against a queue

module cdc_mailbox_tb;

   import mbx_cfg_pkg::*;
   import mbx_reg_pkg::*;

   logic               rclk = 1'b0;
   logic               wclk = 1'b0;
   logic               rrst_n;
   logic               wrst_n;
   logic               psel;
   logic               penable;
   logic               pwrite;
   logic [PADDR_W-1:0] paddr;
   logic [MBX_DW-1:0]  pwdata;
   logic [MBX_DW-1:0]  prdata;
   logic               pready;
   logic               pslverr;
   logic [MBX_DW-1:0]  out_data;
   logic               out_valid;
   logic               out_ready = 1'b0;   // Random throttle below
   logic [MBX_DW-1:0]  in_data;
   logic               in_valid;
   logic               in_ready;

   logic               hold_ready;         // Set by H, cleared by G
   logic [MBX_DW-1:0]  tx_q [$];           // Accepted TXDATA words, oldest first
   logic [MBX_DW-1:0]  exp_w;
   logic [7:0]         op_q [$];           // Parsed stim lines
   logic [31:0]        addr_q [$];
   logic [31:0]        data_q [$];
   logic [31:0]        err_q [$];
   int                 limit = 0;          // Run limit in rclk cycles
   int                 cycles = 0;

   cdc_mailbox u_dut (
      .rclk      (rclk),      .rrst_n    (rrst_n),
      .wclk      (wclk),      .wrst_n    (wrst_n),
      .psel      (psel),      .penable   (penable),
      .pwrite    (pwrite),    .paddr     (paddr),
      .pwdata    (pwdata),    .prdata    (prdata),
      .pready    (pready),    .pslverr   (pslverr),
      .out_data  (out_data),  .out_valid (out_valid),
      .out_ready (out_ready), .in_data   (in_data),
      .in_valid  (in_valid),  .in_ready  (in_ready)
   );

   // FIFO checks in both directions
   bind async_fifo cdc_mailbox_checker #(.DW(DW), .AW(AW)) u_chk (
      .wclk   (wclk),   .wrst_n (wrst_n),
      .rclk   (rclk),   .rrst_n (rrst_n),
      .wptr_g (wptr_g), .rptr_g (rptr_g),
      .pop    (pop),    .empty  (empty),
      .full   (full),   .dout   (dout)
   );

   always #10 rclk = ~rclk;
   always #13 wclk = ~wclk;   // Unrelated to rclk

   task automatic fail_run(input string msg);
      $display("%s", msg);
      $display("Test FAILED");
      $fatal(1, "simulation stopped on error");
   endtask

   task automatic check_resp(input string what,
                             input logic [MBX_DW-1:0] got_d, input logic [MBX_DW-1:0] exp_d,
                             input logic got_e, input logic exp_e);
      assert (got_e == exp_e)
         else fail_run($sformatf("MISMATCH at %0t: %s pslverr %0b, expected %0b",
                                 $time, what, got_e, exp_e));
      assert (got_d == exp_d)
         else fail_run($sformatf("MISMATCH at %0t: %s prdata 0x%08h, expected 0x%08h",
                                 $time, what, got_d, exp_d));
   endtask

   // One APB transfer, returns once pready closes it
   task automatic apb_access(input logic wr, input logic [PADDR_W-1:0] addr,
                             input logic [MBX_DW-1:0] wdata, input int exp_waits,
                             output logic [MBX_DW-1:0] rdata, output logic err);
      int waits;
      waits = 0;
      @(posedge rclk);
      psel    <= 1'b1;          // Setup phase
      penable <= 1'b0;
      pwrite  <= wr;
      paddr   <= addr;
      pwdata  <= wdata;
      @(posedge rclk);
      penable <= 1'b1;          // Access phase
      @(posedge rclk);
      while (!pready) begin
         waits++;
         @(posedge rclk);       // RXDATA pop adds a wait state
      end
      assert (waits == exp_waits)
         else fail_run($sformatf("MISMATCH at %0t: access to 0x%0h took %0d wait states, expected %0d",
                                 $time, addr, waits, exp_waits));
      rdata = prdata;
      err   = pslverr;
      psel    <= 1'b0;
      penable <= 1'b0;
   endtask

   task automatic stream_push(input logic [MBX_DW-1:0] word);
      @(posedge wclk);
      in_data  <= word;
      in_valid <= 1'b1;
      @(posedge wclk);
      while (!in_ready)
         @(posedge wclk);       // RX full, peripheral waits
      in_valid <= 1'b0;
   endtask

   // Read all operation lines up front, size the run limit from their count
   task automatic load_stim();
      int          fd;
      int          n;
      string       line;
      logic [7:0]  op;
      logic [31:0] a;
      logic [31:0] d;
      logic [31:0] e;
      fd = $fopen("dv/cdc_mailbox_stim.txt", "r");
      if (fd == 0) begin
         fail_run("Cannot open the stimulus file dv/cdc_mailbox_stim.txt");
      end else begin
         while (!$feof(fd)) begin
            n = $fgets(line, fd);
            if (n > 0 && line.getc(0) != "#") begin
               n = $sscanf(line, "%c %h %h %h", op, a, d, e);
               if (n == 4) begin
                  op_q.push_back(op);
                  addr_q.push_back(a);
                  data_q.push_back(d);
                  err_q.push_back(e);
               end
            end
         end
         $fclose(fd);
         limit = 200 * op_q.size() + 100;   // Margin for reset
      end
   endtask

   task automatic run_op(input logic [7:0] op, input logic [31:0] a,
                         input logic [31:0] d, input logic [31:0] e);
      logic [MBX_DW-1:0] rd;
      logic              er;
      int                nw;
      case (op)
         "W": begin
            if (a[PADDR_W-1:0] == REG_TXDATA && !e[0])
               tx_q.push_back(d);             // Due on the out stream
            apb_access(1'b1, a[PADDR_W-1:0], d, 0, rd, er);
            assert (er == e[0])
               else fail_run($sformatf("MISMATCH at %0t: write to 0x%0h pslverr %0b, expected %0b",
                                       $time, a, er, e[0]));
         end
         "R": begin
            // Only a valid RXDATA pop waits one cycle
            nw = (a[PADDR_W-1:0] == REG_RXDATA && !e[0]) ? 1 : 0;
            apb_access(1'b0, a[PADDR_W-1:0], '0, nw, rd, er);
            check_resp($sformatf("read of 0x%0h", a), rd, d, er, e[0]);
         end
         "S": begin
            apb_access(1'b0, REG_STATUS, '0, 0, rd, er);
            check_resp("status read", rd, d, er, e[0]);
         end
         "I": stream_push(d);
         "H": begin
            @(posedge rclk);
            hold_ready <= 1'b1;
         end
         "G": begin
            @(posedge rclk);
            hold_ready <= 1'b0;
         end
         "D": repeat (d) @(posedge rclk);     // Let the crossing settle
         default: fail_run($sformatf("Unknown opcode %c in the stimulus file", op));
      endcase
   endtask

   // Peripheral sink, low about 30% of the time unless held
   always @(posedge wclk) begin
      if (hold_ready)
         out_ready <= 1'b0;
      else
         out_ready <= ($urandom % 10) >= 3;
   end

   // Every out-stream transfer against the oldest accepted word
   always @(posedge wclk) begin
      if (wrst_n && out_valid && out_ready) begin
         if (tx_q.size() == 0) begin
            fail_run($sformatf("Out stream delivered 0x%08h at %0t with no word outstanding",
                               out_data, $time));
         end else begin
            exp_w = tx_q.pop_front();
            assert (out_data == exp_w)
               else fail_run($sformatf("MISMATCH at %0t: out_data 0x%08h, expected 0x%08h",
                                       $time, out_data, exp_w));
         end
      end
   end

   always @(posedge rclk) begin
      cycles <= cycles + 1;
      if (limit > 0 && cycles >= limit)
         fail_run($sformatf("Timeout: the run did not finish within %0d rclk cycles", limit));
   end

   initial begin
      int unsigned fails;
      void'($urandom(65));
      psel       <= 1'b0;
      penable    <= 1'b0;
      pwrite     <= 1'b0;
      paddr      <= '0;
      pwdata     <= '0;
      in_data    <= '0;
      in_valid   <= 1'b0;
      hold_ready <= 1'b0;
      rrst_n     <= 1'b0;
      wrst_n     <= 1'b0;
      load_stim();
      repeat (4) @(posedge rclk);
      rrst_n <= 1'b1;
      wrst_n <= 1'b1;
      for (int i = 0; i < op_q.size(); i++)
         run_op(op_q[i], addr_q[i], data_q[i], err_q[i]);
      fails = u_dut.u_tx_fifo.u_chk.fail_cnt + u_dut.u_rx_fifo.u_chk.fail_cnt;
      if (tx_q.size() == 0 && fails == 0) begin
         $display("Test OK");
         $finish;
      end else begin
         fail_run($sformatf("%0d TX words never delivered, %0d FIFO assertion failures",
                            tx_q.size(), fails));
      end
   end

endmodule

/* dv/cdc_mailbox_stim.txt */
# Columns: op addr data err, all hex
# W/R: APB write or read at addr, data is write data or expected prdata, err is expected pslverr
# S: status read, data is the expected status word
# I: push data on the input stream, H/G: hold or release out_ready, D: wait data rclk cycles
# Reset state, RXDATA read on an empty FIFO
S 8 00000002 0
R 4 00000000 1
# TX words under random out_ready
W 0 a5a50001 0
W 0 a5a50002 0
W 0 a5a50003 0
W 0 a5a50004 0
D 0 00000040 0
# RX words from the input stream
I 0 5a5a1001 0
I 0 5a5a1002 0
I 0 5a5a1003 0
D 0 00000010 0
R 4 5a5a1001 0
R 4 5a5a1002 0
R 4 5a5a1003 0
S 8 00000002 0
# Back-pressure, one word waits in the output register and eight fill the FIFO
H 0 00000000 0
W 0 c0de0001 0
W 0 c0de0002 0
W 0 c0de0003 0
W 0 c0de0004 0
W 0 c0de0005 0
W 0 c0de0006 0
W 0 c0de0007 0
W 0 c0de0008 0
W 0 c0de0009 0
D 0 00000020 0
S 8 00000003 0
W 0 deadbeef 1
G 0 00000000 0
D 0 00000060 0
# Error responses leave the flags alone
W 8 11111111 1
R c 00000000 1
W c 22222222 1
S 8 00000002 0
D 0 00000010 0

/* cdc_mailbox.f */
src/mbx_cfg_pkg.sv
src/mbx_reg_pkg.sv
src/async_fifo.sv
src/apb_mbx_regs.sv
src/stream_tx_port.sv
src/cdc_mailbox.sv
dv/cdc_mailbox_checker.sv
dv/cdc_mailbox_tb.sv

/* Makefile */
# Verilator flow for the CDC mailbox

TB_TOP  = cdc_mailbox_tb
RTL_TOP = cdc_mailbox

.PHONY: sim lint clean

sim:
	verilator --binary --timing --assert -j 0 --top-module $(TB_TOP) -f cdc_mailbox.f
	@out="$$(./obj_dir/V$(TB_TOP) +verilator+error+limit+100)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'Test OK'

lint:
	verilator --lint-only -Wall --top-module $(RTL_TOP) \
		src/mbx_cfg_pkg.sv src/mbx_reg_pkg.sv src/async_fifo.sv \
		src/apb_mbx_regs.sv src/stream_tx_port.sv src/cdc_mailbox.sv

clean:
	rm -rf obj_dir
